// File: verilog/vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

//////////////////////////////////////////////////
// raster timing for 640x480 at 60 Hz
//////////////////////////////////////////////////

`define H_TOTAL             10'd800 // columns per line
`define V_TOTAL             10'd525 // lines per frame
`define H_SYNC              10'd96  // hsync pulse width
`define V_SYNC              10'd2   // vsync pulse width
`define H_VIS_FIRST         10'd144 // first visible column
`define H_VIS_LAST          10'd783 // last visible column
`define V_VIS_FIRST         10'd35  // first visible line
`define V_VIS_LAST          10'd514 // last visible line

//////////////////////////////////////////////////
// scene regions with inclusive bounds
//////////////////////////////////////////////////

`define BODY_H_FIRST        10'd192
`define BODY_H_LAST         10'd730
`define BODY_V_FIRST        10'd88
`define BODY_V_LAST         10'd469

`define WIN_H_FIRST         10'd233 // door window
`define WIN_H_LAST          10'd551
`define WIN_V_FIRST         10'd135
`define WIN_V_LAST          10'd438

`define PANEL_H_FIRST       10'd574 // control panel columns
`define PANEL_H_LAST        10'd709
`define BAND_BLACK_V_FIRST  10'd162
`define BAND_BLACK_V_LAST   10'd217
`define BAND_DARK_V_FIRST   10'd234
`define BAND_DARK_V_LAST    10'd360
`define BAND_LIGHT_V_FIRST  10'd383
`define BAND_LIGHT_V_LAST   10'd438

//////////////////////////////////////////////////
// channel values per shade
//////////////////////////////////////////////////

`define CH_WHITE            4'hF
`define CH_GREY             4'h8
`define CH_GLASS            4'hB
`define CH_BLACK            4'h0
`define CH_BROWN_DARK       4'h6
`define CH_BROWN_LIGHT      4'hA
`define CH_YELLOW_RG        4'hC // red and green
`define CH_YELLOW_B         4'h0

`endif

// File: verilog/vga_timing_pkg.sv
package vga_timing_pkg;

    // raster column or line number
    // 10 bits covers the 800-column line
    typedef logic [9:0] count_t;

    // one colour channel of the 12-bit output
    typedef logic [3:0] channel_t;

endpackage

// File: verilog/microwave_scene_pkg.sv
package microwave_scene_pkg;

    // shade of one scene region
    // decoded from the raster position, then looked up into channels
    typedef enum logic [2:0]
    {
        white       = 3'd0, // background
        grey        = 3'd1, // oven body
        glass       = 3'd2, // door window while the oven is idle
        yellow      = 3'd3, // door window while the oven runs
        black       = 3'd4, // top panel band
        brown_dark  = 3'd5, // middle panel band
        brown_light = 3'd6  // bottom panel band
    } shade_e;

endpackage

// File: verilog/vga_timing.sv
`timescale 1ns/1ps

`include "vga_macros.svh"

module vga_timing
(
    input  logic                   clk_25MHz,
    input  logic                   arst_n,
    output vga_timing_pkg::count_t h_count,
    output vga_timing_pkg::count_t v_count,
    output logic                   hsync,
    output logic                   vsync
);

    logic h_wrap; // last column of the line
    logic v_wrap; // last line of the frame

    assign h_wrap = (h_count == `H_TOTAL - 10'd1);
    assign v_wrap = (v_count == `V_TOTAL - 10'd1);

    //////////////////////////////////////////////////
    // horizontal counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk_25MHz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_count <= '0;
        end
        else if (h_wrap)
        begin
            h_count <= '0;
        end
        else
        begin
            h_count <= h_count + 10'd1;
        end
    end

    //////////////////////////////////////////////////
    // vertical counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk_25MHz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            v_count <= '0;
        end
        else if (h_wrap)
        begin
            if (v_wrap)
            begin
                v_count <= '0;
            end
            else
            begin
                v_count <= v_count + 10'd1; // one line down
            end
        end
    end

    // active-high pulses at the start of line and frame
    assign hsync = (h_count < `H_SYNC);
    assign vsync = (v_count < `V_SYNC);

endmodule

// File: verilog/microwave_painter.sv
`timescale 1ns/1ps

`include "vga_macros.svh"

module microwave_painter
(
    input  logic                     clk_25MHz,
    input  logic                     arst_n,
    input  vga_timing_pkg::count_t   h_count,
    input  vga_timing_pkg::count_t   v_count,
    input  logic                     start,
    output vga_timing_pkg::channel_t red,
    output vga_timing_pkg::channel_t green,
    output vga_timing_pkg::channel_t blue
);

    microwave_scene_pkg::shade_e shade;

    vga_timing_pkg::channel_t red_lu;   // looked-up channels
    vga_timing_pkg::channel_t green_lu;
    vga_timing_pkg::channel_t blue_lu;

    vga_timing_pkg::channel_t red_pix;  // after blanking
    vga_timing_pkg::channel_t green_pix;
    vga_timing_pkg::channel_t blue_pix;

    logic in_body;
    logic in_window;
    logic in_panel_cols;
    logic visible;

    // inclusive range test on a raster coordinate
    function automatic logic in_span
    (
        input vga_timing_pkg::count_t pos,
        input vga_timing_pkg::count_t first,
        input vga_timing_pkg::count_t last
    );
        return (pos >= first) && (pos <= last);
    endfunction

    //////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////

    assign in_body = in_span(h_count, `BODY_H_FIRST, `BODY_H_LAST)
                  && in_span(v_count, `BODY_V_FIRST, `BODY_V_LAST);

    assign in_window = in_span(h_count, `WIN_H_FIRST, `WIN_H_LAST)
                    && in_span(v_count, `WIN_V_FIRST, `WIN_V_LAST);

    assign in_panel_cols = in_span(h_count, `PANEL_H_FIRST, `PANEL_H_LAST);

    always_comb
    begin
        if (!in_body)
        begin
            shade = microwave_scene_pkg::white;
        end
        else if (in_window)
        begin
            // window lights up while the oven runs
            shade = start ? microwave_scene_pkg::yellow : microwave_scene_pkg::glass;
        end
        else if (in_panel_cols && in_span(v_count, `BAND_BLACK_V_FIRST, `BAND_BLACK_V_LAST))
        begin
            shade = microwave_scene_pkg::black;
        end
        else if (in_panel_cols && in_span(v_count, `BAND_DARK_V_FIRST, `BAND_DARK_V_LAST))
        begin
            shade = microwave_scene_pkg::brown_dark;
        end
        else if (in_panel_cols && in_span(v_count, `BAND_LIGHT_V_FIRST, `BAND_LIGHT_V_LAST))
        begin
            shade = microwave_scene_pkg::brown_light;
        end
        else
        begin
            shade = microwave_scene_pkg::grey; // rest of the body
        end
    end

    //////////////////////////////////////////////////
    // shade lookup
    //////////////////////////////////////////////////

    always_comb
    begin
        red_lu   = `CH_WHITE;
        green_lu = `CH_WHITE;
        blue_lu  = `CH_WHITE;
        case (shade)
            microwave_scene_pkg::grey:
            begin
                red_lu   = `CH_GREY;
                green_lu = `CH_GREY;
                blue_lu  = `CH_GREY;
            end
            microwave_scene_pkg::glass:
            begin
                red_lu   = `CH_GLASS;
                green_lu = `CH_GLASS;
                blue_lu  = `CH_GLASS;
            end
            microwave_scene_pkg::yellow:
            begin
                red_lu   = `CH_YELLOW_RG;
                green_lu = `CH_YELLOW_RG;
                blue_lu  = `CH_YELLOW_B; // no blue in yellow
            end
            microwave_scene_pkg::black:
            begin
                red_lu   = `CH_BLACK;
                green_lu = `CH_BLACK;
                blue_lu  = `CH_BLACK;
            end
            microwave_scene_pkg::brown_dark:
            begin
                red_lu   = `CH_BROWN_DARK;
                green_lu = `CH_BROWN_DARK;
                blue_lu  = `CH_BROWN_DARK;
            end
            microwave_scene_pkg::brown_light:
            begin
                red_lu   = `CH_BROWN_LIGHT;
                green_lu = `CH_BROWN_LIGHT;
                blue_lu  = `CH_BROWN_LIGHT;
            end
            default:
            begin
                red_lu   = `CH_WHITE; // background
                green_lu = `CH_WHITE;
                blue_lu  = `CH_WHITE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // blanking and output register
    //////////////////////////////////////////////////

    assign visible = in_span(h_count, `H_VIS_FIRST, `H_VIS_LAST)
                  && in_span(v_count, `V_VIS_FIRST, `V_VIS_LAST);

    assign red_pix   = visible ? red_lu   : '0;
    assign green_pix = visible ? green_lu : '0;
    assign blue_pix  = visible ? blue_lu  : '0;

    always_ff @(posedge clk_25MHz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else
        begin
            red   <= red_pix; // one cycle behind the counts
            green <= green_pix;
            blue  <= blue_pix;
        end
    end

endmodule

// File: verilog/microwave_display.sv
`timescale 1ns/1ps

module microwave_display
(
    input  logic                     clk_25MHz,
    input  logic                     arst_n,
    input  logic                     start,
    output logic                     hsync,
    output logic                     vsync,
    output vga_timing_pkg::channel_t red,
    output vga_timing_pkg::channel_t green,
    output vga_timing_pkg::channel_t blue
);

    vga_timing_pkg::count_t h_count; // raster column
    vga_timing_pkg::count_t v_count; // raster line

    //////////////////////////////////////////////////
    // raster timing
    //////////////////////////////////////////////////

    vga_timing u_vga_timing
    (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .h_count   (h_count),
        .v_count   (v_count),
        .hsync     (hsync),   // straight to the connector
        .vsync     (vsync)
    );

    //////////////////////////////////////////////////
    // scene painter
    //////////////////////////////////////////////////

    microwave_painter u_microwave_painter
    (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .h_count   (h_count),
        .v_count   (v_count),
        .start     (start),
        .red       (red),     // registered one cycle after sync
        .green     (green),
        .blue      (blue)
    );

endmodule

// File: tests/microwave_display_asserts.sv
`timescale 1ns/1ps

`include "vga_macros.svh"

module microwave_display_asserts
(
    input logic                     clk_25MHz,
    input logic                     arst_n,
    input vga_timing_pkg::count_t   h_count,
    input vga_timing_pkg::count_t   v_count,
    input logic                     hsync,
    input logic                     vsync,
    input vga_timing_pkg::channel_t red,
    input vga_timing_pkg::channel_t green,
    input vga_timing_pkg::channel_t blue
);

    logic       visible;
    logic [7:0] hsync_run; // cycles seen with hsync high

    assign visible = (h_count >= `H_VIS_FIRST) && (h_count <= `H_VIS_LAST)
                  && (v_count >= `V_VIS_FIRST) && (v_count <= `V_VIS_LAST);

    always_ff @(posedge clk_25MHz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hsync_run <= '0;
        end
        else if (hsync)
        begin
            hsync_run <= hsync_run + 8'd1;
        end
        else
        begin
            hsync_run <= '0;
        end
    end

    //////////////////////////////////////////////////
    // blanking and sync properties
    //////////////////////////////////////////////////

    blank_after_border: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        !visible |=> (red == 4'h0) && (green == 4'h0) && (blue == 4'h0))
        else $error("colour is not zero one cycle after a non-visible position");

    hsync_width: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        $fell(hsync) |-> (hsync_run == 8'd96))
        else $error("hsync pulse is not 96 cycles wide");

    vsync_at_line_start: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        $rose(vsync) |-> (h_count == 10'd0))
        else $error("vsync rose away from column 0");

endmodule

bind microwave_display microwave_display_asserts u_microwave_display_asserts
(
    .clk_25MHz (clk_25MHz),
    .arst_n    (arst_n),
    .h_count   (h_count),
    .v_count   (v_count),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue)
);

// File: tests/tb_microwave_display.sv
`timescale 1ns/1ps

`include "vga_macros.svh"

module tb_microwave_display;

    localparam int CLK_HALF_NS  = 20;
    localparam int RESET_CYCLES = 4;
    localparam int RUN_FRAMES   = 3;
    localparam int FRAME_CYCLES = int'(`H_TOTAL) * int'(`V_TOTAL);
    localparam int WATCHDOG_NS  = (RUN_FRAMES + 1) * FRAME_CYCLES * 2 * CLK_HALF_NS;

    localparam vga_timing_pkg::count_t MID_WINDOW = 10'd392; // toggle point inside the door

    logic                     clk_25MHz;
    logic                     arst_n;
    logic                     start;
    logic                     hsync;
    logic                     vsync;
    vga_timing_pkg::channel_t red;
    vga_timing_pkg::channel_t green;
    vga_timing_pkg::channel_t blue;

    vga_timing_pkg::count_t   m_h; // model raster position
    vga_timing_pkg::count_t   m_v;
    logic [15:0]              lfsr;
    int                       shade_seen [0:6];

    microwave_display u_microwave_display
    (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .start     (start),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial
    begin
        clk_25MHz = 1'b0;
        forever #(CLK_HALF_NS) clk_25MHz = ~clk_25MHz;
    end

    //////////////////////////////////////////////////
    // helpers and reference model
    //////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic between
    (
        input vga_timing_pkg::count_t pos,
        input vga_timing_pkg::count_t lo,
        input vga_timing_pkg::count_t hi
    );
        return (pos >= lo) && (pos <= hi);
    endfunction

    function automatic void model_pixel
    (
        input  vga_timing_pkg::count_t      h,
        input  vga_timing_pkg::count_t      v,
        input  logic                        st,
        output microwave_scene_pkg::shade_e s,
        output logic                        vis,
        output vga_timing_pkg::channel_t    r,
        output vga_timing_pkg::channel_t    g,
        output vga_timing_pkg::channel_t    b
    );
        logic panel;
        panel = between(h, `PANEL_H_FIRST, `PANEL_H_LAST);
        vis = between(h, `H_VIS_FIRST, `H_VIS_LAST) && between(v, `V_VIS_FIRST, `V_VIS_LAST);
        if (!(between(h, `BODY_H_FIRST, `BODY_H_LAST) && between(v, `BODY_V_FIRST, `BODY_V_LAST)))
            s = microwave_scene_pkg::white;
        else if (between(h, `WIN_H_FIRST, `WIN_H_LAST) && between(v, `WIN_V_FIRST, `WIN_V_LAST))
            s = st ? microwave_scene_pkg::yellow : microwave_scene_pkg::glass;
        else if (panel && between(v, `BAND_BLACK_V_FIRST, `BAND_BLACK_V_LAST))
            s = microwave_scene_pkg::black;
        else if (panel && between(v, `BAND_DARK_V_FIRST, `BAND_DARK_V_LAST))
            s = microwave_scene_pkg::brown_dark;
        else if (panel && between(v, `BAND_LIGHT_V_FIRST, `BAND_LIGHT_V_LAST))
            s = microwave_scene_pkg::brown_light;
        else
            s = microwave_scene_pkg::grey;
        case (s)
            microwave_scene_pkg::grey:        {r, g, b} = {3{`CH_GREY}};
            microwave_scene_pkg::glass:       {r, g, b} = {3{`CH_GLASS}};
            microwave_scene_pkg::yellow:      {r, g, b} = {`CH_YELLOW_RG, `CH_YELLOW_RG,
                                                           `CH_YELLOW_B};
            microwave_scene_pkg::black:       {r, g, b} = {3{`CH_BLACK}};
            microwave_scene_pkg::brown_dark:  {r, g, b} = {3{`CH_BROWN_DARK}};
            microwave_scene_pkg::brown_light: {r, g, b} = {3{`CH_BROWN_LIGHT}};
            default:                          {r, g, b} = {3{`CH_WHITE}};
        endcase
        if (!vis)
            {r, g, b} = 12'h000; // blanked border
    endfunction

    task automatic advance_position();
        if (m_h == `H_TOTAL - 10'd1)
        begin
            m_h = '0;
            m_v = (m_v == `V_TOTAL - 10'd1) ? 10'd0 : m_v + 10'd1;
        end
        else
        begin
            m_h = m_h + 10'd1;
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_sync(input string test, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s expected %b actual %b", test, expected, actual);
            fail_run($sformatf("wrong sync at model line %0d column %0d", m_v, m_h));
        end
    endtask

    task automatic check_channel
    (
        input string                    test,
        input vga_timing_pkg::channel_t expected,
        input vga_timing_pkg::channel_t actual
    );
        if (actual !== expected)
        begin
            $display("Mismatch %s expected %h actual %h", test, expected, actual);
            fail_run($sformatf("wrong colour at model line %0d column %0d", m_v, m_h));
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus and checking
    //////////////////////////////////////////////////

    initial
    begin
        microwave_scene_pkg::shade_e nxt_shade;
        logic                        nxt_vis;
        vga_timing_pkg::channel_t    nxt_red;
        vga_timing_pkg::channel_t    nxt_green;
        vga_timing_pkg::channel_t    nxt_blue;
        int                          missing;
        arst_n = 1'b0;
        start  = 1'b0;
        lfsr   = 16'd30030;
        m_h    = '0;
        m_v    = '0;
        for (int i = 0; i < 7; i++)
            shade_seen[i] = 0;

        repeat (RESET_CYCLES)
        begin
            @(posedge clk_25MHz);
            #2;
            check_sync("reset hsync", 1'b1, hsync); // counts held at 0
            check_sync("reset vsync", 1'b1, vsync);
            check_channel("reset red", 4'h0, red);
            check_channel("reset green", 4'h0, green);
            check_channel("reset blue", 4'h0, blue);
        end
        arst_n = 1'b1;
        #(CLK_HALF_NS); // halfway to the first counting edge
        check_sync("release hsync", 1'b1, hsync);
        check_sync("release vsync", 1'b1, vsync);
        check_channel("release red", 4'h0, red);
        check_channel("release green", 4'h0, green);
        check_channel("release blue", 4'h0, blue);

        for (int cyc = 0; cyc < RUN_FRAMES * FRAME_CYCLES; cyc++)
        begin
            model_pixel(m_h, m_v, start, nxt_shade, nxt_vis, nxt_red, nxt_green, nxt_blue);
            @(posedge clk_25MHz);
            #2;
            advance_position();
            check_sync("hsync", m_h < `H_SYNC, hsync);
            check_sync("vsync", m_v < `V_SYNC, vsync);
            check_channel("red", nxt_red, red); // colour of the previous position
            check_channel("green", nxt_green, green);
            check_channel("blue", nxt_blue, blue);
            if (nxt_vis)
                shade_seen[int'(nxt_shade)] += 1;
            if ((m_h == 10'd0) || (m_h == MID_WINDOW))
            begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0])
                    start = ~start;
            end
        end

        missing = 0;
        for (int s = 0; s < 7; s++)
            if (shade_seen[s] == 0)
                missing++;
        if (missing == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            fail_run($sformatf("%0d scene shades never appeared on screen", missing));
        end
    end

    // four frame times
    initial
    begin
        #(WATCHDOG_NS);
        fail_run("the run timed out before three frames were checked");
    end

endmodule

// File: compile.f
+incdir+verilog
verilog/vga_timing_pkg.sv
verilog/microwave_scene_pkg.sv
verilog/vga_timing.sv
verilog/microwave_painter.sv
verilog/microwave_display.sv
tests/microwave_display_asserts.sv
tests/tb_microwave_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the microwave display testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_microwave_display \
    -o sim_microwave_display

./obj_dir/sim_microwave_display 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation finished, see sim.log"
exit 0
